// ==== sata_pkg.sv ====
// SATA device package with shared widths, primitive and FIS codes, and phy states
package sata_pkg;

  // Line and stack transfer unit
  typedef logic [31:0] dword_t;

  typedef logic [47:0] lba_t;
  typedef logic [15:0] sector_count_t;
  typedef logic [7:0]  ata_cmd_t;
  typedef logic [7:0]  ata_status_t;

  // Out-of-band phy sequence
  typedef enum logic [2:0] {
    WAIT_RESET, SEND_INIT, WAIT_WAKE, SEND_WAKE, SEND_ALIGN, READY
  } oob_state_t;

  // Primitives, always sent with the k flag set
  localparam dword_t PRIM_ALIGN = 32'h7B4A_4ABC;
  localparam dword_t PRIM_SYNC  = 32'hB5B5_957C;
  localparam dword_t PRIM_SOF   = 32'h3737_B57C;
  localparam dword_t PRIM_EOF   = 32'hD5D5_B57C;
  localparam dword_t PRIM_R_OK  = 32'h3535_B57C;
  localparam dword_t PRIM_R_ERR = 32'h5656_B57C;

  // Register FIS types and length
  localparam logic [7:0]  FIS_H2D_REG    = 8'h27;
  localparam logic [7:0]  FIS_D2H_REG    = 8'h34;
  localparam int unsigned REG_FIS_DWORDS = 5;

  // Seed of the running XOR check word
  localparam dword_t CHECK_SEED = 32'h5232_5032;

endpackage

// ==== hd_phy_oob.sv ====
// Device phy that answers the host OOB reset and wake bursts, then aligns
`timescale 1ns/1ps

module hd_phy_oob import sata_pkg::*; #(
  parameter int OOB_BURST = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  dword_t     rx_din,
  input  logic       rx_is_k,
  input  logic       comm_reset_detect,
  input  logic       comm_wake_detect,
  output dword_t     tx_dout,
  output logic       tx_is_k,
  output logic       tx_comm_reset,
  output logic       tx_comm_wake,
  output logic       phy_ready,
  output oob_state_t oob_state
);

  localparam int CNT_W = $clog2(OOB_BURST + 1);

  oob_state_t       state;
  logic [CNT_W-1:0] burst_cnt;
  logic             burst_done;
  logic             align_seen;

  assign burst_done = (burst_cnt == CNT_W'(OOB_BURST - 1));
  assign align_seen = rx_is_k && (rx_din == PRIM_ALIGN);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= WAIT_RESET;
      burst_cnt <= '0;
    end else begin
      // Counter only runs inside a burst state
      burst_cnt <= '0;
      case (state)
        SEND_INIT: begin
          burst_cnt <= burst_cnt + 1'b1;
          if (burst_done) state <= WAIT_WAKE;
        end
        SEND_WAKE: begin
          burst_cnt <= burst_cnt + 1'b1;
          if (burst_done) state <= SEND_ALIGN;
        end
        WAIT_WAKE: begin
          if (comm_reset_detect) state <= SEND_INIT;
          else if (comm_wake_detect) state <= SEND_WAKE;
        end
        SEND_ALIGN: begin
          if (comm_reset_detect) state <= SEND_INIT;
          else if (align_seen) state <= READY;
        end
        // Host reset restarts the whole exchange
        default: if (comm_reset_detect) state <= SEND_INIT;
      endcase
    end
  end

  assign tx_comm_reset = (state == SEND_INIT);
  assign tx_comm_wake  = (state == SEND_WAKE);
  assign phy_ready     = (state == READY);
  assign oob_state     = state;
  assign tx_dout       = (state == SEND_ALIGN) ? PRIM_ALIGN : '0;
  assign tx_is_k       = (state == SEND_ALIGN);

  // A comm burst only ends once the counter has run its full length
  a_burst_full: assert property (
    @(posedge clk) disable iff (!rst_n)
      $fell(tx_comm_reset) || $fell(tx_comm_wake) |-> $past(burst_done));

endmodule

// ==== link_rx.sv ====
// Link receiver that frames host dwords, forwards payload and checks the XOR word
`timescale 1ns/1ps

module link_rx import sata_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   phy_ready,
  input  dword_t rx_din,
  input  logic   rx_is_k,
  output logic   pay_valid,
  output dword_t pay_data,
  output logic   frame_done,
  output logic   frame_good
);

  typedef enum logic {RX_IDLE, RX_FRAME} rx_state_t;

  rx_state_t state;
  logic      held_valid;
  dword_t    held_data;
  dword_t    check;
  logic      is_sof;
  logic      is_eof;
  logic      data_in;

  assign is_sof  = rx_is_k && (rx_din == PRIM_SOF);
  assign is_eof  = rx_is_k && (rx_din == PRIM_EOF);
  assign data_in = phy_ready && (state == RX_FRAME) && !rx_is_k;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= RX_IDLE;
      held_valid <= 1'b0;
      check      <= '0;
      pay_valid  <= 1'b0;
      frame_done <= 1'b0;
      frame_good <= 1'b0;
    end else begin
      pay_valid  <= 1'b0;
      frame_done <= 1'b0;
      if (!phy_ready) begin
        state      <= RX_IDLE;
        held_valid <= 1'b0;
      end else if (is_sof) begin
        state      <= RX_FRAME;
        held_valid <= 1'b0;
        check      <= CHECK_SEED;
      end else if (is_eof && state == RX_FRAME) begin
        // Held dword is the check word here
        state      <= RX_IDLE;
        held_valid <= 1'b0;
        frame_done <= 1'b1;
        frame_good <= held_valid && (held_data == check);
      end else if (data_in) begin
        if (held_valid) begin
          pay_valid <= 1'b1;
          check     <= check ^ held_data;
        end
        held_valid <= 1'b1;
      end
    end
  end

  // One dword of delay keeps the check word off the payload port
  always_ff @(posedge clk) begin
    if (data_in) begin
      held_data <= rx_din;
      pay_data  <= held_data;
    end
  end

endmodule

// ==== link_tx.sv ====
// Link transmitter for SYNC, R_OK/R_ERR answers and outgoing device frames
`timescale 1ns/1ps

module link_tx import sata_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   phy_ready,
  input  logic   frame_done,
  input  logic   frame_good,
  input  logic   d2h_valid,
  input  dword_t d2h_data,
  input  logic   d2h_last,
  output logic   d2h_ready,
  output dword_t tx_dout,
  output logic   tx_is_k
);

  typedef enum logic [2:0] {
    TX_IDLE, TX_STATUS, TX_SOF, TX_DATA, TX_CHECK, TX_EOF
  } tx_state_t;

  tx_state_t state;
  logic      stat_pending;
  logic      stat_good;
  logic      stat_send_good;
  dword_t    check;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= TX_IDLE;
      stat_pending   <= 1'b0;
      stat_good      <= 1'b0;
      stat_send_good <= 1'b0;
      check          <= '0;
    end else if (!phy_ready) begin
      state        <= TX_IDLE;
      stat_pending <= 1'b0;
    end else begin
      // A new result wins over clearing the old one
      if (frame_done) begin
        stat_pending <= 1'b1;
        stat_good    <= frame_good;
      end else if (state == TX_IDLE && stat_pending) begin
        stat_pending <= 1'b0;
      end
      case (state)
        TX_IDLE: begin
          if (stat_pending) begin
            state          <= TX_STATUS;
            stat_send_good <= stat_good;
          end else if (d2h_valid) begin
            state <= TX_SOF;
          end
        end
        TX_STATUS: state <= TX_IDLE;
        TX_SOF: begin
          state <= TX_DATA;
          check <= CHECK_SEED;
        end
        TX_DATA: begin
          if (d2h_valid) begin
            check <= check ^ d2h_data;
            if (d2h_last) state <= TX_CHECK;
          end
        end
        TX_CHECK: state <= TX_EOF;
        default:  state <= TX_IDLE;
      endcase
    end
  end

  assign d2h_ready = (state == TX_DATA);

  always_comb begin
    tx_is_k = 1'b1;
    tx_dout = PRIM_SYNC;
    case (state)
      TX_STATUS: tx_dout = stat_send_good ? PRIM_R_OK : PRIM_R_ERR;
      TX_SOF:    tx_dout = PRIM_SOF;
      TX_EOF:    tx_dout = PRIM_EOF;
      TX_CHECK: begin
        tx_dout = check;
        tx_is_k = 1'b0;
      end
      TX_DATA: begin
        // Idle gap inside a frame shows as SYNC
        if (d2h_valid) begin
          tx_dout = d2h_data;
          tx_is_k = 1'b0;
        end
      end
      default: tx_dout = PRIM_SYNC;
    endcase
  end

  // Outgoing words hold still until the sequencer takes them
  a_d2h_hold: assert property (
    @(posedge clk) disable iff (!rst_n) d2h_valid && !d2h_ready |=>
      d2h_valid && $stable(d2h_data) && $stable(d2h_last));

endmodule

// ==== h2d_fis_decoder.sv ====
// Transport decoder that turns a good H2D register FIS into a held command
`timescale 1ns/1ps

module h2d_fis_decoder import sata_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          pay_valid,
  input  dword_t        pay_data,
  input  logic          frame_done,
  input  logic          frame_good,
  input  logic          cmd_ready,
  output logic          cmd_valid,
  output ata_cmd_t      h2d_command,
  output lba_t          h2d_lba,
  output sector_count_t h2d_sector_count
);

  logic [2:0]    word_cnt;
  logic [7:0]    stage_type;
  logic          stage_cmd_bit;
  ata_cmd_t      stage_command;
  lba_t          stage_lba;
  sector_count_t stage_count;
  logic          commit;

  assign commit = frame_done && frame_good && !cmd_valid &&
                  (word_cnt == 3'(REG_FIS_DWORDS)) &&
                  (stage_type == FIS_H2D_REG) && stage_cmd_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt  <= '0;
      cmd_valid <= 1'b0;
    end else begin
      // Saturates one past a register FIS so long frames fail the length test
      if (frame_done) word_cnt <= '0;
      else if (pay_valid && word_cnt != 3'(REG_FIS_DWORDS + 1)) word_cnt <= word_cnt + 1'b1;
      if (commit) cmd_valid <= 1'b1;
      else if (cmd_ready) cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pay_valid) begin
      case (word_cnt)
        3'd0: begin
          stage_type    <= pay_data[7:0];
          stage_cmd_bit <= pay_data[15];
          stage_command <= pay_data[23:16];
        end
        3'd1:    stage_lba[23:0]  <= pay_data[23:0];
        3'd2:    stage_lba[47:24] <= pay_data[23:0];
        3'd3:    stage_count      <= pay_data[15:0];
        default: ;
      endcase
    end
    if (commit) begin
      h2d_command      <= stage_command;
      h2d_lba          <= stage_lba;
      h2d_sector_count <= stage_count;
    end
  end

  a_cmd_stable: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_valid && !cmd_ready |=>
      cmd_valid && $stable(h2d_command) && $stable(h2d_lba) && $stable(h2d_sector_count));

endmodule

// ==== hd_command_layer.sv ====
// Command layer that takes the drive handshake and builds the D2H register FIS
`timescale 1ns/1ps

module hd_command_layer import sata_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cmd_valid,
  input  lba_t          h2d_lba,
  input  sector_count_t h2d_sector_count,
  input  logic          cmd_ready,
  input  ata_status_t   d2h_status,
  input  logic          d2h_ready,
  output logic          d2h_valid,
  output dword_t        d2h_data,
  output logic          d2h_last
);

  logic          busy;
  logic [2:0]    word_idx;
  ata_status_t   cap_status;
  lba_t          cap_lba;
  sector_count_t cap_count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      word_idx <= '0;
    end else if (!busy) begin
      // A handshake during a reply is not captured
      if (cmd_valid && cmd_ready) begin
        busy     <= 1'b1;
        word_idx <= '0;
      end
    end else if (d2h_ready) begin
      if (d2h_last) busy <= 1'b0;
      else word_idx <= word_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && cmd_valid && cmd_ready) begin
      cap_status <= d2h_status;
      cap_lba    <= h2d_lba;
      cap_count  <= h2d_sector_count;
    end
  end

  assign d2h_valid = busy;
  assign d2h_last  = (word_idx == 3'(REG_FIS_DWORDS - 1));

  // Interrupt bit always set, error byte zero
  always_comb begin
    case (word_idx)
      3'd0:    d2h_data = {8'h00, cap_status, 2'b01, 6'b000000, FIS_D2H_REG};
      3'd1:    d2h_data = {8'h00, cap_lba[23:0]};
      3'd2:    d2h_data = {8'h00, cap_lba[47:24]};
      3'd3:    d2h_data = {16'h0000, cap_count};
      default: d2h_data = '0;
    endcase
  end

endmodule

// ==== faux_sata_hd.sv ====
// Faux SATA drive top with phy, link, transport and command layers
`timescale 1ns/1ps

module faux_sata_hd import sata_pkg::*; #(
  parameter int OOB_BURST = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  dword_t        rx_din,
  input  logic          rx_is_k,
  input  logic          comm_reset_detect,
  input  logic          comm_wake_detect,
  output dword_t        tx_dout,
  output logic          tx_is_k,
  output logic          tx_comm_reset,
  output logic          tx_comm_wake,
  output logic          phy_ready,
  output oob_state_t    oob_state,
  output logic          cmd_valid,
  output ata_cmd_t      h2d_command,
  output lba_t          h2d_lba,
  output sector_count_t h2d_sector_count,
  input  logic          cmd_ready,
  input  ata_status_t   d2h_status
);

  dword_t phy_tx_dout;
  logic   phy_tx_is_k;
  dword_t ll_tx_dout;
  logic   ll_tx_is_k;
  logic   pay_valid;
  dword_t pay_data;
  logic   frame_done;
  logic   frame_good;
  logic   d2h_valid;
  dword_t d2h_data;
  logic   d2h_last;
  logic   d2h_ready;

  hd_phy_oob #(.OOB_BURST(OOB_BURST)) u_phy (
    .clk, .rst_n, .rx_din, .rx_is_k, .comm_reset_detect, .comm_wake_detect,
    .tx_dout(phy_tx_dout), .tx_is_k(phy_tx_is_k),
    .tx_comm_reset, .tx_comm_wake, .phy_ready, .oob_state
  );

  link_rx u_link_rx (
    .clk, .rst_n, .phy_ready, .rx_din, .rx_is_k,
    .pay_valid, .pay_data, .frame_done, .frame_good
  );

  link_tx u_link_tx (
    .clk, .rst_n, .phy_ready, .frame_done, .frame_good,
    .d2h_valid, .d2h_data, .d2h_last, .d2h_ready,
    .tx_dout(ll_tx_dout), .tx_is_k(ll_tx_is_k)
  );

  h2d_fis_decoder u_decoder (
    .clk, .rst_n, .pay_valid, .pay_data, .frame_done, .frame_good, .cmd_ready,
    .cmd_valid, .h2d_command, .h2d_lba, .h2d_sector_count
  );

  hd_command_layer u_cmd (
    .clk, .rst_n, .cmd_valid, .h2d_lba, .h2d_sector_count, .cmd_ready,
    .d2h_status, .d2h_ready, .d2h_valid, .d2h_data, .d2h_last
  );

  // Phy owns the line until alignment completes
  assign tx_dout = phy_ready ? ll_tx_dout : phy_tx_dout;
  assign tx_is_k = phy_ready ? ll_tx_is_k : phy_tx_is_k;

endmodule

// ==== tb_faux_sata_hd.sv ====
// Self-checking testbench for the faux SATA drive with host and drive models
`timescale 1ns/1ps

module tb_faux_sata_hd import sata_pkg::*; ();

  localparam int OOB_BURST = 4;
  localparam int TIMEOUT   = 300;
  localparam int N_CASES   = 4;

  typedef struct packed {
    ata_cmd_t      cmd;
    lba_t          lba;
    sector_count_t count;
    ata_status_t   status;
    logic          corrupt;
    logic [7:0]    fis_type;
  } case_t;

  logic          clk;
  logic          rst_n;
  dword_t        rx_din;
  logic          rx_is_k;
  logic          comm_reset_detect;
  logic          comm_wake_detect;
  dword_t        tx_dout;
  logic          tx_is_k;
  logic          tx_comm_reset;
  logic          tx_comm_wake;
  logic          phy_ready;
  oob_state_t    oob_state;
  logic          cmd_valid;
  ata_cmd_t      h2d_command;
  lba_t          h2d_lba;
  sector_count_t h2d_sector_count;
  logic          cmd_ready;
  ata_status_t   d2h_status;

  int            mismatch_cnt;
  int            fail_cnt;
  int            cmd_rise_cnt;
  int            seed;
  case_t         cases [N_CASES];

  logic          prev_valid;
  logic          prev_ready;
  ata_cmd_t      prev_cmd;
  lba_t          prev_lba;
  sector_count_t prev_count;

  faux_sata_hd #(.OOB_BURST(OOB_BURST)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Drive side watch: held fields and count of new commands
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_valid && !prev_ready) begin
        assert (cmd_valid && h2d_command == prev_cmd && h2d_lba == prev_lba &&
                h2d_sector_count == prev_count) else begin
          $display("Command dropped or changed while cmd_ready was low");
          fail_cnt++;
        end
      end
      if (cmd_valid && !prev_valid) cmd_rise_cnt++;
    end
    prev_valid = cmd_valid;
    prev_ready = cmd_ready;
    prev_cmd   = h2d_command;
    prev_lba   = h2d_lba;
    prev_count = h2d_sector_count;
  end

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  function automatic logic watched(input int sel);
    case (sel)
      0:       return tx_comm_reset;
      1:       return tx_comm_wake;
      2:       return phy_ready;
      default: return cmd_valid;
    endcase
  endfunction

  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    while (!watched(sel) && n < TIMEOUT) begin
      tick();
      n++;
    end
    assert (n < TIMEOUT) else begin
      $display("Timed out waiting for %s to rise", what);
      fail_cnt++;
    end
  endtask

  task automatic measure_pulse(input int sel, input string what);
    int n;
    wait_high(sel, what);
    n = 0;
    while (watched(sel) && n < TIMEOUT) begin
      tick();
      n++;
    end
    check_val(what, 64'(n), 64'(OOB_BURST));
  endtask

  task automatic wait_prim(input dword_t prim, input string what);
    int n;
    n = 0;
    while (!(tx_is_k && tx_dout == prim) && n < TIMEOUT) begin
      tick();
      n++;
    end
    assert (n < TIMEOUT) else begin
      $display("Timed out waiting for %s on tx_dout", what);
      fail_cnt++;
    end
  endtask

  task automatic drive_line(input dword_t d, input logic k);
    rx_din  = d;
    rx_is_k = k;
    tick();
  endtask

  // Host frame with its own XOR check word, optionally damaged
  task automatic send_frame(input dword_t words [5], input logic corrupt);
    dword_t chk;
    int     i;
    chk = CHECK_SEED;
    drive_line(PRIM_SOF, 1'b1);
    for (i = 0; i < 5; i++) begin
      drive_line(words[i], 1'b0);
      chk = chk ^ words[i];
    end
    if (corrupt) chk = chk ^ 32'h0000_0100;
    drive_line(chk, 1'b0);
    drive_line(PRIM_EOF, 1'b1);
    rx_din  = PRIM_SYNC;
    rx_is_k = 1'b1;
  endtask

  task automatic wait_status(input dword_t exp);
    int n;
    n = 0;
    while (!(tx_is_k && (tx_dout == PRIM_R_OK || tx_dout == PRIM_R_ERR)) &&
           n < TIMEOUT) begin
      tick();
      n++;
    end
    assert (n < TIMEOUT) else begin
      $display("Timed out waiting for a frame status primitive");
      fail_cnt++;
    end
    if (n < TIMEOUT) check_val("tx_dout", 64'(tx_dout), 64'(exp));
    tick();
  endtask

  // Data dwords between SOF and EOF, SYNC gaps skipped
  task automatic collect_frame(output dword_t words [6], output int count);
    int n;
    wait_prim(PRIM_SOF, "SOF");
    tick();
    n     = 0;
    count = 0;
    while (!(tx_is_k && tx_dout == PRIM_EOF) && n < TIMEOUT) begin
      if (!tx_is_k) begin
        if (count < 6) words[count] = tx_dout;
        count++;
      end
      tick();
      n++;
    end
    assert (n < TIMEOUT) else begin
      $display("Timed out waiting for EOF of the device frame");
      fail_cnt++;
    end
  endtask

  initial begin
    dword_t req [5];
    dword_t got [6];
    dword_t exp [6];
    int     c;
    int     i;
    int     hold;
    int     n_got;
    int     exp_cmds;
    logic   good_cmd;
    rst_n             = 1'b0;
    rx_din            = '0;
    rx_is_k           = 1'b0;
    comm_reset_detect = 1'b0;
    comm_wake_detect  = 1'b0;
    cmd_ready         = 1'b0;
    d2h_status        = '0;
    mismatch_cnt      = 0;
    fail_cnt          = 0;
    cmd_rise_cnt      = 0;
    exp_cmds          = 0;
    seed              = 32'hd1d0;
    cases[0] = '{8'h25, 48'h0000_1234_5678, 16'h0010, 8'h50, 1'b0, FIS_H2D_REG};
    cases[1] = '{8'h35, 48'h0000_0000_0800, 16'h0001, 8'h50, 1'b1, FIS_H2D_REG};
    cases[2] = '{8'h25, 48'h0000_0000_0040, 16'h0002, 8'h50, 1'b0, 8'h46};
    cases[3] = '{8'hC8, 48'hABCD_EF01_2345, 16'hFFFF, 8'h51, 1'b0, FIS_H2D_REG};
    repeat (8) tick();
    rst_n = 1'b1;
    tick();
    check_val("phy_ready", 64'(phy_ready), 64'(0));
    check_val("tx_comm_reset", 64'(tx_comm_reset), 64'(0));
    check_val("tx_comm_wake", 64'(tx_comm_wake), 64'(0));
    check_val("oob_state", 64'(oob_state), 64'(WAIT_RESET));

    // OOB reset and wake answers, then alignment
    comm_reset_detect = 1'b1;
    tick();
    comm_reset_detect = 1'b0;
    measure_pulse(0, "tx_comm_reset");
    check_val("oob_state", 64'(oob_state), 64'(WAIT_WAKE));
    comm_wake_detect = 1'b1;
    tick();
    comm_wake_detect = 1'b0;
    measure_pulse(1, "tx_comm_wake");
    check_val("oob_state", 64'(oob_state), 64'(SEND_ALIGN));
    wait_prim(PRIM_ALIGN, "ALIGN");
    rx_din  = PRIM_ALIGN;
    rx_is_k = 1'b1;
    wait_high(2, "phy_ready");
    rx_din = PRIM_SYNC;
    check_val("oob_state", 64'(oob_state), 64'(READY));
    check_val("tx_dout", 64'(tx_dout), 64'(PRIM_SYNC));
    check_val("tx_is_k", 64'(tx_is_k), 64'(1));

    for (c = 0; c < N_CASES; c++) begin
      req[0] = {8'h00, cases[c].cmd, 8'h80, cases[c].fis_type};
      req[1] = {8'h00, cases[c].lba[23:0]};
      req[2] = {8'h00, cases[c].lba[47:24]};
      req[3] = {16'h0000, cases[c].count};
      req[4] = '0;
      good_cmd = !cases[c].corrupt && cases[c].fis_type == FIS_H2D_REG;
      send_frame(req, cases[c].corrupt);
      wait_status(cases[c].corrupt ? PRIM_R_ERR : PRIM_R_OK);
      if (good_cmd) begin
        exp_cmds++;
        wait_high(3, "cmd_valid");
        check_val("h2d_command", 64'(h2d_command), 64'(cases[c].cmd));
        check_val("h2d_lba", 64'(h2d_lba), 64'(cases[c].lba));
        check_val("h2d_sector_count", 64'(h2d_sector_count), 64'(cases[c].count));
        // Drive busy for a while, another command arrives meanwhile
        hold = 5 + int'($unsigned($random(seed)) % 26);
        repeat (hold) tick();
        req[0] = {8'h00, 8'hEC, 8'h80, FIS_H2D_REG};
        send_frame(req, 1'b0);
        wait_status(PRIM_R_OK);
        d2h_status = cases[c].status;
        cmd_ready  = 1'b1;
        tick();
        cmd_ready  = 1'b0;
        d2h_status = '0;
        exp[0] = {8'h00, cases[c].status, 8'h40, FIS_D2H_REG};
        exp[1] = {8'h00, cases[c].lba[23:0]};
        exp[2] = {8'h00, cases[c].lba[47:24]};
        exp[3] = {16'h0000, cases[c].count};
        exp[4] = '0;
        exp[5] = CHECK_SEED ^ exp[0] ^ exp[1] ^ exp[2] ^ exp[3] ^ exp[4];
        collect_frame(got, n_got);
        check_val("d2h frame length", 64'(n_got), 64'(6));
        for (i = 0; i < 6 && i < n_got; i++) begin
          check_val($sformatf("d2h dword %0d", i), 64'(got[i]), 64'(exp[i]));
        end
      end
      // Quiet window with no new command
      for (i = 0; i < 50; i++) begin
        assert (!cmd_valid) else begin
          $display("Unexpected cmd_valid after table entry %0d", c);
          fail_cnt++;
        end
        tick();
      end
      check_val("cmd_valid rises", 64'(cmd_rise_cnt), 64'(exp_cmds));
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
sata_pkg.sv
hd_phy_oob.sv
link_rx.sv
link_tx.sv
h2d_fis_decoder.sv
hd_command_layer.sv
faux_sata_hd.sv
tb_faux_sata_hd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the faux SATA drive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_faux_sata_hd \
  -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
